//--- design/axi2iob_pkg.sv
/*
 * AXI4 to IOb adapter shared definitions
 * burst field widths, response codes and the IOb port owner
 */
package axi2iob_pkg;

   // AXI4 burst field widths
   localparam int BURST_LEN_W  = 8;
   localparam int BURST_SIZE_W = 3;

   // response field width on B and R
   localparam int RESP_W = 2;

   typedef logic [RESP_W-1:0] resp_t;

   // the adapter never reports an error
   localparam resp_t RESP_OKAY = resp_t'(0);

   // number of beats minus one
   typedef logic [BURST_LEN_W-1:0] burst_len_t;

   // log2 of bytes per beat
   typedef logic [BURST_SIZE_W-1:0] burst_size_t;

   // engine that currently holds the IOb port
   typedef enum logic {
      OWNER_WR,
      OWNER_RD
   } owner_t;

endpackage

//--- design/axi_wr_burst_engine.sv
/*
 * AXI4 write burst engine
 * splits each INCR write burst into single IOb write accesses and
 * returns one B response per burst
 */
`timescale 1ns/100ps

module axi_wr_burst_engine #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32,
   parameter int ID_W   = 8
) (
   input  logic                     clk_i,
   input  logic                     arst_i,
   input  logic [ID_W-1:0]          s_axi_awid_i,
   input  logic [ADDR_W-1:0]        s_axi_awaddr_i,
   input  axi2iob_pkg::burst_len_t  s_axi_awlen_i,
   input  axi2iob_pkg::burst_size_t s_axi_awsize_i,
   input  logic                     s_axi_awvalid_i,
   output logic                     s_axi_awready_o,
   input  logic [DATA_W-1:0]        s_axi_wdata_i,
   input  logic [DATA_W/8-1:0]      s_axi_wstrb_i,
   input  logic                     s_axi_wvalid_i,
   output logic                     s_axi_wready_o,
   output logic [ID_W-1:0]          s_axi_bid_o,
   output axi2iob_pkg::resp_t       s_axi_bresp_o,
   output logic                     s_axi_bvalid_o,
   input  logic                     s_axi_bready_i,
   output logic                     wr_req_o,
   output logic [ADDR_W-1:0]        wr_addr_o,
   output logic [DATA_W-1:0]        wr_data_o,
   output logic [DATA_W/8-1:0]      wr_strb_o,
   input  logic                     wr_ack_i
);

   localparam int STRB_W = DATA_W / 8;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_DATA,
      WR_ISSUE
   } wr_state_t;

   wr_state_t                state_q;
   logic [ID_W-1:0]          id_q;
   logic [ADDR_W-1:0]        addr_q;
   axi2iob_pkg::burst_len_t  len_q;
   axi2iob_pkg::burst_size_t size_q;
   logic [DATA_W-1:0]        data_q;
   logic [STRB_W-1:0]        strb_q;
   logic                     awready_q;
   logic                     wready_q;
   logic                     bvalid_q;
   logic                     req_q;
   logic                     aw_fire;
   logic                     w_fire;
   logic                     beat_done;
   logic [ADDR_W-1:0]        addr_step;

   assign aw_fire   = awready_q && s_axi_awvalid_i;
   assign w_fire    = wready_q && s_axi_wvalid_i;
   assign addr_step = ADDR_W'(1) << size_q;

   // a beat without strobes never raises a request and completes at once
   assign beat_done = (state_q == WR_ISSUE) && (wr_ack_i || !req_q);

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q   <= WR_IDLE;
         awready_q <= 1'b0;
         wready_q  <= 1'b0;
         bvalid_q  <= 1'b0;
         req_q     <= 1'b0;
         len_q     <= '0;
         size_q    <= '0;
      end else begin
         case (state_q)
            WR_IDLE: begin
               if (bvalid_q) begin
                  if (s_axi_bready_i) begin
                     bvalid_q  <= 1'b0;
                     awready_q <= 1'b1;
                  end
               end else if (aw_fire) begin
                  awready_q <= 1'b0;
                  wready_q  <= 1'b1;
                  len_q     <= s_axi_awlen_i;
                  size_q    <= s_axi_awsize_i;
                  state_q   <= WR_DATA;
               end else begin
                  awready_q <= 1'b1;
               end
            end
            WR_DATA: begin
               if (w_fire) begin
                  wready_q <= 1'b0;
                  req_q    <= |s_axi_wstrb_i;
                  state_q  <= WR_ISSUE;
               end
            end
            WR_ISSUE: begin
               if (beat_done) begin
                  req_q <= 1'b0;
                  // the beat count ends the burst and wlast is never looked at
                  if (len_q == '0) begin
                     bvalid_q <= 1'b1;
                     state_q  <= WR_IDLE;
                  end else begin
                     len_q    <= len_q - axi2iob_pkg::burst_len_t'(1);
                     wready_q <= 1'b1;
                     state_q  <= WR_DATA;
                  end
               end
            end
            default: state_q <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (aw_fire) begin
         id_q   <= s_axi_awid_i;
         addr_q <= s_axi_awaddr_i;
      end else if (beat_done) begin
         addr_q <= addr_q + addr_step;
      end
      if (w_fire) begin
         data_q <= s_axi_wdata_i;
         strb_q <= s_axi_wstrb_i;
      end
   end

   assign s_axi_awready_o = awready_q;
   assign s_axi_wready_o  = wready_q;
   assign s_axi_bid_o     = id_q;
   assign s_axi_bresp_o   = axi2iob_pkg::RESP_OKAY;
   assign s_axi_bvalid_o  = bvalid_q;

   assign wr_req_o  = req_q;
   assign wr_addr_o = addr_q;
   assign wr_data_o = data_q;
   assign wr_strb_o = strb_q;

endmodule

//--- design/axi_rd_burst_engine.sv
/*
 * AXI4 read burst engine
 * splits each INCR read burst into single IOb reads and returns R beats
 */
`timescale 1ns/100ps

module axi_rd_burst_engine #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32,
   parameter int ID_W   = 8
) (
   input  logic                     clk_i,
   input  logic                     arst_i,
   input  logic [ID_W-1:0]          s_axi_arid_i,
   input  logic [ADDR_W-1:0]        s_axi_araddr_i,
   input  axi2iob_pkg::burst_len_t  s_axi_arlen_i,
   input  axi2iob_pkg::burst_size_t s_axi_arsize_i,
   input  logic                     s_axi_arvalid_i,
   output logic                     s_axi_arready_o,
   output logic [ID_W-1:0]          s_axi_rid_o,
   output logic [DATA_W-1:0]        s_axi_rdata_o,
   output axi2iob_pkg::resp_t       s_axi_rresp_o,
   output logic                     s_axi_rlast_o,
   output logic                     s_axi_rvalid_o,
   input  logic                     s_axi_rready_i,
   output logic                     rd_req_o,
   output logic [ADDR_W-1:0]        rd_addr_o,
   input  logic                     rd_ack_i,
   input  logic                     rd_rvalid_i,
   input  logic [DATA_W-1:0]        rd_rdata_i
);

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ISSUE,
      RD_WAIT,
      RD_RESP
   } rd_state_t;

   rd_state_t                state_q;
   logic [ID_W-1:0]          id_q;
   logic [ADDR_W-1:0]        addr_q;
   axi2iob_pkg::burst_len_t  len_q;
   axi2iob_pkg::burst_size_t size_q;
   logic [DATA_W-1:0]        rdata_q;
   logic                     arready_q;
   logic                     rvalid_q;
   logic                     rlast_q;
   logic                     req_q;
   logic                     ar_fire;
   logic                     r_fire;
   logic                     data_in;

   assign ar_fire = arready_q && s_axi_arvalid_i;
   assign r_fire  = rvalid_q && s_axi_rready_i;
   assign data_in = (state_q == RD_WAIT) && rd_rvalid_i;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q   <= RD_IDLE;
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
         rlast_q   <= 1'b0;
         req_q     <= 1'b0;
         len_q     <= '0;
         size_q    <= '0;
      end else begin
         case (state_q)
            RD_IDLE: begin
               if (ar_fire) begin
                  arready_q <= 1'b0;
                  len_q     <= s_axi_arlen_i;
                  size_q    <= s_axi_arsize_i;
                  req_q     <= 1'b1;
                  state_q   <= RD_ISSUE;
               end else begin
                  arready_q <= 1'b1;
               end
            end
            RD_ISSUE: begin
               if (rd_ack_i) begin
                  req_q   <= 1'b0;
                  state_q <= RD_WAIT;
               end
            end
            RD_WAIT: begin
               if (rd_rvalid_i) begin
                  rvalid_q <= 1'b1;
                  rlast_q  <= (len_q == '0);
                  state_q  <= RD_RESP;
               end
            end
            RD_RESP: begin
               if (r_fire) begin
                  rvalid_q <= 1'b0;
                  rlast_q  <= 1'b0;
                  if (len_q == '0) begin
                     arready_q <= 1'b1;
                     state_q   <= RD_IDLE;
                  end else begin
                     len_q   <= len_q - axi2iob_pkg::burst_len_t'(1);
                     req_q   <= 1'b1;
                     state_q <= RD_ISSUE;
                  end
               end
            end
            default: state_q <= RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (ar_fire) begin
         id_q   <= s_axi_arid_i;
         addr_q <= s_axi_araddr_i;
      end else if (r_fire) begin
         addr_q <= addr_q + (ADDR_W'(1) << size_q);
      end
      if (data_in) begin
         rdata_q <= rd_rdata_i;
      end
   end

   assign s_axi_arready_o = arready_q;
   assign s_axi_rid_o     = id_q;
   assign s_axi_rdata_o   = rdata_q;
   assign s_axi_rresp_o   = axi2iob_pkg::RESP_OKAY;
   assign s_axi_rlast_o   = rlast_q;
   assign s_axi_rvalid_o  = rvalid_q;

   assign rd_req_o  = req_q;
   assign rd_addr_o = addr_q;

endmodule

//--- design/iob_access_arbiter.sv
/*
 * IOb access arbiter
 * grants the single IOb port to the write or the read engine, reads win ties
 */
`timescale 1ns/100ps

module iob_access_arbiter #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic                clk_i,
   input  logic                arst_i,
   input  logic                wr_req_i,
   input  logic [ADDR_W-1:0]   wr_addr_i,
   input  logic [DATA_W-1:0]   wr_data_i,
   input  logic [DATA_W/8-1:0] wr_strb_i,
   input  logic                rd_req_i,
   input  logic [ADDR_W-1:0]   rd_addr_i,
   output logic                iob_valid_o,
   output logic [ADDR_W-1:0]   iob_addr_o,
   output logic [DATA_W-1:0]   iob_wdata_o,
   output logic [DATA_W/8-1:0] iob_wstrb_o,
   input  logic                iob_ready_i,
   input  logic                iob_rvalid_i,
   input  logic [DATA_W-1:0]   iob_rdata_i,
   output logic                wr_ack_o,
   output logic                rd_ack_o,
   output logic                rd_rvalid_o,
   output logic [DATA_W-1:0]   rd_rdata_o
);

   localparam int STRB_W = DATA_W / 8;

   axi2iob_pkg::owner_t owner_q;
   axi2iob_pkg::owner_t owner;
   logic                lock_q;
   logic                rd_sel;
   logic                accept;

   // grant follows the requests while the port is free and stays frozen while locked
   always_comb begin
      if (lock_q) begin
         owner = owner_q;
      end else if (rd_req_i) begin
         owner = axi2iob_pkg::OWNER_RD;
      end else begin
         owner = axi2iob_pkg::OWNER_WR;
      end
   end

   assign rd_sel      = (owner == axi2iob_pkg::OWNER_RD);
   assign iob_valid_o = rd_sel ? rd_req_i : wr_req_i;
   assign iob_addr_o  = rd_sel ? rd_addr_i : wr_addr_i;
   assign iob_wdata_o = wr_data_i;
   // zero strobes mark a read on IOb
   assign iob_wstrb_o = rd_sel ? {STRB_W{1'b0}} : wr_strb_i;

   assign accept   = iob_valid_o && iob_ready_i;
   assign wr_ack_o = accept && !rd_sel;
   assign rd_ack_o = accept && rd_sel;

   // only reads return data, so rvalid always belongs to the read engine
   assign rd_rvalid_o = iob_rvalid_i;
   assign rd_rdata_o  = iob_rdata_i;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         owner_q <= axi2iob_pkg::OWNER_WR;
         lock_q  <= 1'b0;
      end else begin
         lock_q <= iob_valid_o && !iob_ready_i;
         if (iob_valid_o) begin
            owner_q <= owner;
         end
      end
   end

endmodule

//--- design/axi2iob_top.sv
/*
 * AXI4 slave to IOb master adapter
 * write and read burst engines share one IOb port through an arbiter
 */
`timescale 1ns/100ps

module axi2iob_top #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32,
   parameter int ID_W   = 8
) (
   input  logic                     clk_i,
   input  logic                     arst_i,

   input  logic [ID_W-1:0]          s_axi_awid_i,
   input  logic [ADDR_W-1:0]        s_axi_awaddr_i,
   input  axi2iob_pkg::burst_len_t  s_axi_awlen_i,
   input  axi2iob_pkg::burst_size_t s_axi_awsize_i,
   input  logic                     s_axi_awvalid_i,
   output logic                     s_axi_awready_o,
   input  logic [DATA_W-1:0]        s_axi_wdata_i,
   input  logic [DATA_W/8-1:0]      s_axi_wstrb_i,
   input  logic                     s_axi_wlast_i,
   input  logic                     s_axi_wvalid_i,
   output logic                     s_axi_wready_o,
   output logic [ID_W-1:0]          s_axi_bid_o,
   output axi2iob_pkg::resp_t       s_axi_bresp_o,
   output logic                     s_axi_bvalid_o,
   input  logic                     s_axi_bready_i,

   input  logic [ID_W-1:0]          s_axi_arid_i,
   input  logic [ADDR_W-1:0]        s_axi_araddr_i,
   input  axi2iob_pkg::burst_len_t  s_axi_arlen_i,
   input  axi2iob_pkg::burst_size_t s_axi_arsize_i,
   input  logic                     s_axi_arvalid_i,
   output logic                     s_axi_arready_o,
   output logic [ID_W-1:0]          s_axi_rid_o,
   output logic [DATA_W-1:0]        s_axi_rdata_o,
   output axi2iob_pkg::resp_t       s_axi_rresp_o,
   output logic                     s_axi_rlast_o,
   output logic                     s_axi_rvalid_o,
   input  logic                     s_axi_rready_i,

   output logic                     iob_valid_o,
   output logic [ADDR_W-1:0]        iob_addr_o,
   output logic [DATA_W-1:0]        iob_wdata_o,
   output logic [DATA_W/8-1:0]      iob_wstrb_o,
   input  logic                     iob_ready_i,
   input  logic                     iob_rvalid_i,
   input  logic [DATA_W-1:0]        iob_rdata_i
);

   localparam int STRB_W = DATA_W / 8;

   logic              wr_req;
   logic [ADDR_W-1:0] wr_addr;
   logic [DATA_W-1:0] wr_data;
   logic [STRB_W-1:0] wr_strb;
   logic              wr_ack;
   logic              rd_req;
   logic [ADDR_W-1:0] rd_addr;
   logic              rd_ack;
   logic              rd_rvalid;
   logic [DATA_W-1:0] rd_rdata;

   // the write engine ends each burst by its beat count and never sees wlast
   axi_wr_burst_engine #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W),
      .ID_W  (ID_W)
   ) wr_engine0 (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .s_axi_awid_i   (s_axi_awid_i),
      .s_axi_awaddr_i (s_axi_awaddr_i),
      .s_axi_awlen_i  (s_axi_awlen_i),
      .s_axi_awsize_i (s_axi_awsize_i),
      .s_axi_awvalid_i(s_axi_awvalid_i),
      .s_axi_awready_o(s_axi_awready_o),
      .s_axi_wdata_i  (s_axi_wdata_i),
      .s_axi_wstrb_i  (s_axi_wstrb_i),
      .s_axi_wvalid_i (s_axi_wvalid_i),
      .s_axi_wready_o (s_axi_wready_o),
      .s_axi_bid_o    (s_axi_bid_o),
      .s_axi_bresp_o  (s_axi_bresp_o),
      .s_axi_bvalid_o (s_axi_bvalid_o),
      .s_axi_bready_i (s_axi_bready_i),
      .wr_req_o       (wr_req),
      .wr_addr_o      (wr_addr),
      .wr_data_o      (wr_data),
      .wr_strb_o      (wr_strb),
      .wr_ack_i       (wr_ack)
   );

   axi_rd_burst_engine #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W),
      .ID_W  (ID_W)
   ) rd_engine0 (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .s_axi_arid_i   (s_axi_arid_i),
      .s_axi_araddr_i (s_axi_araddr_i),
      .s_axi_arlen_i  (s_axi_arlen_i),
      .s_axi_arsize_i (s_axi_arsize_i),
      .s_axi_arvalid_i(s_axi_arvalid_i),
      .s_axi_arready_o(s_axi_arready_o),
      .s_axi_rid_o    (s_axi_rid_o),
      .s_axi_rdata_o  (s_axi_rdata_o),
      .s_axi_rresp_o  (s_axi_rresp_o),
      .s_axi_rlast_o  (s_axi_rlast_o),
      .s_axi_rvalid_o (s_axi_rvalid_o),
      .s_axi_rready_i (s_axi_rready_i),
      .rd_req_o       (rd_req),
      .rd_addr_o      (rd_addr),
      .rd_ack_i       (rd_ack),
      .rd_rvalid_i    (rd_rvalid),
      .rd_rdata_i     (rd_rdata)
   );

   iob_access_arbiter #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) arbiter0 (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .wr_req_i    (wr_req),
      .wr_addr_i   (wr_addr),
      .wr_data_i   (wr_data),
      .wr_strb_i   (wr_strb),
      .rd_req_i    (rd_req),
      .rd_addr_i   (rd_addr),
      .iob_valid_o (iob_valid_o),
      .iob_addr_o  (iob_addr_o),
      .iob_wdata_o (iob_wdata_o),
      .iob_wstrb_o (iob_wstrb_o),
      .iob_ready_i (iob_ready_i),
      .iob_rvalid_i(iob_rvalid_i),
      .iob_rdata_i (iob_rdata_i),
      .wr_ack_o    (wr_ack),
      .rd_ack_o    (rd_ack),
      .rd_rvalid_o (rd_rvalid),
      .rd_rdata_o  (rd_rdata)
   );

endmodule

//--- verification/axi2iob_sva.sv
/*
 * AXI4 to IOb adapter protocol assertions
 * IOb request hold, reset state and B/R hold rules on the top level
 */
`timescale 1ns/100ps

module axi2iob_sva #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32,
   parameter int ID_W   = 8
) (
   input logic                clk_i,
   input logic                arst_i,
   input logic                iob_valid_i,
   input logic [ADDR_W-1:0]   iob_addr_i,
   input logic [DATA_W/8-1:0] iob_wstrb_i,
   input logic                iob_ready_i,
   input logic                bvalid_i,
   input logic                bready_i,
   input logic [ID_W-1:0]     bid_i,
   input logic                rvalid_i,
   input logic                rready_i,
   input logic [DATA_W-1:0]   rdata_i,
   input logic                rlast_i
);

   // number of failed assertions
   int unsigned fail_count = 0;

   iob_valid_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      iob_valid_i && !iob_ready_i |=>
         iob_valid_i && $stable(iob_addr_i) && $stable(iob_wstrb_i))
   else begin
      fail_count++;
      $error("iob request dropped or changed before iob_ready_i");
   end

   reset_quiet: assert property (@(posedge clk_i)
      arst_i |-> !iob_valid_i && !bvalid_i && !rvalid_i)
   else begin
      fail_count++;
      $error("valid output high during reset");
   end

   bvalid_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      bvalid_i && !bready_i |=> bvalid_i && $stable(bid_i))
   else begin
      fail_count++;
      $error("bvalid dropped or bid changed before bready");
   end

   rvalid_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rlast_i))
   else begin
      fail_count++;
      $error("rvalid dropped or R payload changed before rready");
   end

endmodule

bind axi2iob_top axi2iob_sva #(
   .ADDR_W(ADDR_W),
   .DATA_W(DATA_W),
   .ID_W  (ID_W)
) sva0 (
   .clk_i      (clk_i),
   .arst_i     (arst_i),
   .iob_valid_i(iob_valid_o),
   .iob_addr_i (iob_addr_o),
   .iob_wstrb_i(iob_wstrb_o),
   .iob_ready_i(iob_ready_i),
   .bvalid_i   (s_axi_bvalid_o),
   .bready_i   (s_axi_bready_i),
   .bid_i      (s_axi_bid_o),
   .rvalid_i   (s_axi_rvalid_o),
   .rready_i   (s_axi_rready_i),
   .rdata_i    (s_axi_rdata_o),
   .rlast_i    (s_axi_rlast_o)
);

//--- verification/axi2iob_tb.sv
/*
 * AXI4 to IOb adapter testbench
 * random write and read bursts against a byte-strobed IOb memory model
 */
`timescale 1ns/100ps

module axi2iob_tb;

   localparam int ADDR_W      = 32;
   localparam int DATA_W      = 32;
   localparam int ID_W        = 8;
   localparam int STRB_W      = DATA_W / 8;
   localparam int MEM_WORDS   = 256;
   localparam int MEM_BYTES   = MEM_WORDS * STRB_W;
   localparam int SEQ_BURSTS  = 20;
   localparam int PAIR_BURSTS = 10;
   localparam int NUM_BURSTS  = 2 * SEQ_BURSTS + 2 * PAIR_BURSTS;
   localparam int MAX_BEATS   = 8;
   localparam int MAX_DELAY   = 6;
   // worst case beat time with a wide margin
   localparam int CYCLE_LIMIT = NUM_BURSTS * MAX_BEATS * MAX_DELAY * 7;
   // room left at the top of a region for the longest burst
   localparam int BURST_SPAN  = MAX_BEATS * STRB_W;

   logic                     clk_i;
   logic                     arst_i;
   logic [ID_W-1:0]          s_axi_awid_i;
   logic [ADDR_W-1:0]        s_axi_awaddr_i;
   axi2iob_pkg::burst_len_t  s_axi_awlen_i;
   axi2iob_pkg::burst_size_t s_axi_awsize_i;
   logic                     s_axi_awvalid_i;
   logic                     s_axi_awready_o;
   logic [DATA_W-1:0]        s_axi_wdata_i;
   logic [STRB_W-1:0]        s_axi_wstrb_i;
   logic                     s_axi_wlast_i;
   logic                     s_axi_wvalid_i;
   logic                     s_axi_wready_o;
   logic [ID_W-1:0]          s_axi_bid_o;
   axi2iob_pkg::resp_t       s_axi_bresp_o;
   logic                     s_axi_bvalid_o;
   logic                     s_axi_bready_i;
   logic [ID_W-1:0]          s_axi_arid_i;
   logic [ADDR_W-1:0]        s_axi_araddr_i;
   axi2iob_pkg::burst_len_t  s_axi_arlen_i;
   axi2iob_pkg::burst_size_t s_axi_arsize_i;
   logic                     s_axi_arvalid_i;
   logic                     s_axi_arready_o;
   logic [ID_W-1:0]          s_axi_rid_o;
   logic [DATA_W-1:0]        s_axi_rdata_o;
   axi2iob_pkg::resp_t       s_axi_rresp_o;
   logic                     s_axi_rlast_o;
   logic                     s_axi_rvalid_o;
   logic                     s_axi_rready_i;
   logic                     iob_valid_o;
   logic [ADDR_W-1:0]        iob_addr_o;
   logic [DATA_W-1:0]        iob_wdata_o;
   logic [STRB_W-1:0]        iob_wstrb_o;
   logic                     iob_ready_i;
   logic                     iob_rvalid_i;
   logic [DATA_W-1:0]        iob_rdata_i;

   logic [DATA_W-1:0] mem    [MEM_WORDS];
   logic [DATA_W-1:0] shadow [MEM_WORDS];
   int unsigned       check_count    = 0;
   int unsigned       error_count    = 0;
   int unsigned       cycle_count    = 0;
   int unsigned       iob_wr_count   = 0;
   int unsigned       iob_rd_count   = 0;
   int unsigned       exp_wr_access  = 0;
   int unsigned       exp_rd_access  = 0;
   int unsigned       b_count        = 0;
   int unsigned       wr_bursts_done = 0;

   axi2iob_top #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W),
      .ID_W  (ID_W)
   ) dut0 (
      .*
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   initial begin : watchdog
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk_i);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
   end

   always @(posedge clk_i) begin
      if (!arst_i && s_axi_bvalid_o && s_axi_bready_i) begin
         b_count++;
      end
   end

   function automatic logic [DATA_W-1:0] fill_word(input logic [7:0] idx);
      return {idx ^ 8'h3C, ~idx, idx + 8'h11, idx};
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] result;
      result = old_word;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return result;
   endfunction

   // byte lanes that a beat of this size may use at this address
   function automatic logic [STRB_W-1:0] lane_mask(input logic [ADDR_W-1:0] addr,
                                                   input logic [2:0] size);
      case (size)
         3'd0:    return STRB_W'(1) << addr[1:0];
         3'd1:    return addr[1] ? 4'b1100 : 4'b0011;
         default: return '1;
      endcase
   endfunction

   function automatic logic [ADDR_W-1:0] pick_addr(input int unsigned lo,
                                                   input int unsigned span,
                                                   input logic [2:0] size);
      logic [ADDR_W-1:0] addr;
      addr = ADDR_W'(lo + $urandom_range(span - 1));
      return addr & ~((ADDR_W'(1) << size) - ADDR_W'(1));
   endfunction

   task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
      check_count++;
      assert (got === exp)
      else begin
         error_count++;
         $display("CHECK FAILED %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, exp);
      end
   endtask

   task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                              input logic [7:0] len, input logic [2:0] size);
      logic [ADDR_W-1:0] beat_addr;
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic [7:0]        word;
      @(negedge clk_i);
      s_axi_awid_i    = id;
      s_axi_awaddr_i  = addr;
      s_axi_awlen_i   = len;
      s_axi_awsize_i  = size;
      s_axi_awvalid_i = 1'b1;
      do @(posedge clk_i); while (!s_axi_awready_o);
      @(negedge clk_i);
      s_axi_awvalid_i = 1'b0;
      for (int i = 0; i <= len; i++) begin
         beat_addr = addr + (ADDR_W'(i) << size);
         data      = $urandom;
         strb      = STRB_W'($urandom) & lane_mask(beat_addr, size);
         // about one beat in four carries no strobes at all
         if ($urandom_range(3) == 0) begin
            strb = '0;
         end
         word         = beat_addr[9:2];
         shadow[word] = merge_bytes(shadow[word], data, strb);
         if (strb != '0) begin
            exp_wr_access++;
         end
         s_axi_wdata_i  = data;
         s_axi_wstrb_i  = strb;
         s_axi_wlast_i  = (i == len);
         s_axi_wvalid_i = 1'b1;
         do @(posedge clk_i); while (!s_axi_wready_o);
         @(negedge clk_i);
         s_axi_wvalid_i = 1'b0;
      end
      s_axi_bready_i = 1'($urandom_range(1));
      @(posedge clk_i);
      while (!(s_axi_bvalid_o && s_axi_bready_i)) begin
         @(negedge clk_i);
         s_axi_bready_i = 1'($urandom_range(1));
         @(posedge clk_i);
      end
      check_value("s_axi_bid_o", s_axi_bid_o, id);
      check_value("s_axi_bresp_o", s_axi_bresp_o, axi2iob_pkg::RESP_OKAY);
      @(negedge clk_i);
      s_axi_bready_i = 1'b0;
      wr_bursts_done++;
      check_value("b handshake count", b_count, wr_bursts_done);
      for (int i = 0; i <= len; i++) begin
         beat_addr = addr + (ADDR_W'(i) << size);
         word      = beat_addr[9:2];
         check_value($sformatf("mem[%0d]", word), mem[word], shadow[word]);
      end
   endtask

   task automatic read_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                             input logic [7:0] len, input logic [2:0] size);
      logic [ADDR_W-1:0] beat_addr;
      @(negedge clk_i);
      s_axi_arid_i    = id;
      s_axi_araddr_i  = addr;
      s_axi_arlen_i   = len;
      s_axi_arsize_i  = size;
      s_axi_arvalid_i = 1'b1;
      do @(posedge clk_i); while (!s_axi_arready_o);
      @(negedge clk_i);
      s_axi_arvalid_i = 1'b0;
      for (int i = 0; i <= len; i++) begin
         beat_addr = addr + (ADDR_W'(i) << size);
         exp_rd_access++;
         s_axi_rready_i = 1'($urandom_range(1));
         @(posedge clk_i);
         while (!(s_axi_rvalid_o && s_axi_rready_i)) begin
            @(negedge clk_i);
            s_axi_rready_i = 1'($urandom_range(1));
            @(posedge clk_i);
         end
         check_value("s_axi_rid_o", s_axi_rid_o, id);
         check_value("s_axi_rresp_o", s_axi_rresp_o, axi2iob_pkg::RESP_OKAY);
         check_value("s_axi_rdata_o", s_axi_rdata_o, shadow[beat_addr[9:2]]);
         check_value("s_axi_rlast_o", s_axi_rlast_o, (i == len));
         @(negedge clk_i);
         s_axi_rready_i = 1'b0;
      end
   endtask

   // IOb memory that takes one access at a time with random ready and read latency
   initial begin : iob_memory_model
      int unsigned       delay;
      logic [DATA_W-1:0] pend_data;
      logic [7:0]        word;
      delay        = 0;
      pend_data    = '0;
      iob_ready_i  = 1'b0;
      iob_rvalid_i = 1'b0;
      iob_rdata_i  = '0;
      forever begin
         @(posedge clk_i);
         if (!arst_i && iob_valid_o && iob_ready_i) begin
            word = iob_addr_o[9:2];
            if (iob_wstrb_o != '0) begin
               mem[word] = merge_bytes(mem[word], iob_wdata_o, iob_wstrb_o);
               iob_wr_count++;
            end else begin
               pend_data = mem[word];
               delay     = $urandom_range(3, 1);
               iob_rd_count++;
            end
         end
         @(negedge clk_i);
         iob_rvalid_i = 1'b0;
         if (delay != 0) begin
            delay--;
            if (delay == 0) begin
               iob_rvalid_i = 1'b1;
               iob_rdata_i  = pend_data;
            end
         end
         iob_ready_i = ($urandom_range(3) != 0);
      end
   end

   initial begin : stimulus
      logic [7:0]        len;
      logic [7:0]        rlen;
      logic [2:0]        size;
      logic [2:0]        rsize;
      logic [ADDR_W-1:0] addr;
      logic [ADDR_W-1:0] raddr;
      int unsigned       sva_fails;
      void'($urandom(92));
      arst_i          = 1'b1;
      s_axi_awid_i    = '0;
      s_axi_awaddr_i  = '0;
      s_axi_awlen_i   = '0;
      s_axi_awsize_i  = '0;
      s_axi_awvalid_i = 1'b0;
      s_axi_wdata_i   = '0;
      s_axi_wstrb_i   = '0;
      s_axi_wlast_i   = 1'b0;
      s_axi_wvalid_i  = 1'b0;
      s_axi_bready_i  = 1'b0;
      s_axi_arid_i    = '0;
      s_axi_araddr_i  = '0;
      s_axi_arlen_i   = '0;
      s_axi_arsize_i  = '0;
      s_axi_arvalid_i = 1'b0;
      s_axi_rready_i  = 1'b0;
      for (int w = 0; w < MEM_WORDS; w++) begin
         mem[w]    = fill_word(8'(w));
         shadow[w] = mem[w];
      end

      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      arst_i = 1'b0;
      check_value("iob_valid_o", iob_valid_o, 1'b0);
      check_value("s_axi_bvalid_o", s_axi_bvalid_o, 1'b0);
      check_value("s_axi_rvalid_o", s_axi_rvalid_o, 1'b0);
      check_value("s_axi_wready_o", s_axi_wready_o, 1'b0);
      @(negedge clk_i);
      check_value("s_axi_awready_o", s_axi_awready_o, 1'b1);
      check_value("s_axi_arready_o", s_axi_arready_o, 1'b1);

      // reads over the whole memory follow the writes and see their data
      for (int n = 0; n < SEQ_BURSTS; n++) begin
         len  = 8'($urandom_range(MAX_BEATS - 1));
         size = 3'($urandom_range(2));
         addr = pick_addr(0, MEM_BYTES - BURST_SPAN, size);
         write_burst(ID_W'($urandom), addr, len, size);
      end
      for (int n = 0; n < SEQ_BURSTS; n++) begin
         len  = 8'($urandom_range(MAX_BEATS - 1));
         size = 3'($urandom_range(2));
         addr = pick_addr(0, MEM_BYTES - BURST_SPAN, size);
         read_burst(ID_W'($urandom), addr, len, size);
      end

      // overlapping bursts with writes in the lower half and reads in the upper half
      for (int n = 0; n < PAIR_BURSTS; n++) begin
         len   = 8'($urandom_range(MAX_BEATS - 1));
         size  = 3'($urandom_range(2));
         addr  = pick_addr(0, MEM_BYTES / 2 - BURST_SPAN, size);
         rlen  = 8'($urandom_range(MAX_BEATS - 1));
         rsize = 3'($urandom_range(2));
         raddr = pick_addr(MEM_BYTES / 2, MEM_BYTES / 2 - BURST_SPAN, rsize);
         fork
            write_burst(ID_W'($urandom), addr, len, size);
            read_burst(ID_W'($urandom), raddr, rlen, rsize);
         join
      end

      repeat (MAX_DELAY) @(negedge clk_i);
      check_value("iob write accesses", iob_wr_count, exp_wr_access);
      check_value("iob read accesses", iob_rd_count, exp_rd_access);
      check_value("b handshake count", b_count, wr_bursts_done);
      sva_fails = dut0.sva0.fail_count;
      $display("checks: %0d, check errors: %0d, assertion failures: %0d",
               check_count, error_count, sva_fails);
      if (error_count == 0 && sva_fails == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- verilog.f
design/axi2iob_pkg.sv
design/axi_wr_burst_engine.sv
design/axi_rd_burst_engine.sv
design/iob_access_arbiter.sv
design/axi2iob_top.sv
verification/axi2iob_sva.sv
verification/axi2iob_tb.sv

//--- Bender.yml
package:
  name: axi2iob

sources:
  - files:
      - design/axi2iob_pkg.sv
      - design/axi_wr_burst_engine.sv
      - design/axi_rd_burst_engine.sv
      - design/iob_access_arbiter.sv
      - design/axi2iob_top.sv
  - target: test
    files:
      - verification/axi2iob_sva.sv
      - verification/axi2iob_tb.sv
